/* src/conv_weights_pkg.sv */
package conv_weights_pkg;

  //////////////////////////////
  // weight encoding
  //////////////////////////////

  // one vector is 64 x 8bit or 128 x 1bit weights
  typedef enum logic {
    mode_8bit = 1'b0,  // one buffer word per vector
    mode_1bit = 1'b1   // four vectors packed in one word
  } weight_mode_e;

  // vectors held by one word in 1bit mode
  localparam int VECS_PER_WORD_1BIT = 4;

  //////////////////////////////
  // layer configuration
  //////////////////////////////

  // latched by load_start, recorded per bank
  typedef struct packed {
    weight_mode_e mode;       // 8bit or 1bit weights
    logic [15:0]  vec_count;  // vectors per tile, nif*k*k
    logic [15:0]  ddr_base;   // first ddr word of the tile
  } layer_cfg_t;

  // cleared record, bank holds no tile
  localparam layer_cfg_t LAYER_CFG_EMPTY = '{
    mode:      mode_8bit,
    vec_count: '0,
    ddr_base:  '0
  };

endpackage

/* src/weights_mem_pkg.sv */
package weights_mem_pkg;

  //////////////////////////////
  // word format
  //////////////////////////////

  // ddr word and buffer word are the same size
  localparam int WORD_W = 512;

  //////////////////////////////
  // ddr read channel
  //////////////////////////////

  // request, taken when valid and ddr_ready
  typedef struct packed {
    logic        valid;  // request pending
    logic [15:0] addr;   // ddr word address
  } ddr_rd_req_t;

  // response, in request order, one cycle each
  typedef struct packed {
    logic              valid;  // data valid this cycle
    logic [WORD_W-1:0] data;   // returned word
  } ddr_rd_rsp_t;

  //////////////////////////////
  // buffer port
  //////////////////////////////

  typedef struct packed {
    logic              en;    // port active
    logic              wr;    // 1 write, 0 read
    logic [15:0]       addr;  // word address in bank
    logic [WORD_W-1:0] data;  // write data
  } buf_port_t;

endpackage

/* src/weights_buffer.sv */
`timescale 1ns/100ps

module weights_buffer
  import weights_mem_pkg::*;
#(
  parameter int BUF_DEPTH_LOG2 = 12  // words per bank, log2
) (
  input  logic              clk,
  input  buf_port_t         port,  // single shared port
  output logic [WORD_W-1:0] dout   // registered read data
);

  localparam int DEPTH = 2 ** BUF_DEPTH_LOG2;

  logic [WORD_W-1:0]         mem [DEPTH];
  logic [BUF_DEPTH_LOG2-1:0] addr;

  assign addr = port.addr[BUF_DEPTH_LOG2-1:0];  // upper bits ignored

  always_ff @(posedge clk) begin
    if (port.en) begin
      if (port.wr) begin
        mem[addr] <= port.data;  // write, dout holds
      end else begin
        dout <= mem[addr];  // read, one cycle latency
      end
    end
  end

endmodule

/* src/conv_load_weights_controller.sv */
`timescale 1ns/100ps

module conv_load_weights_controller
  import conv_weights_pkg::*;
  import weights_mem_pkg::*;
#(
  parameter int BUF_DEPTH_LOG2 = 12  // bank address width
) (
  input  logic        clk,
  input  logic        reset,
  input  logic        load_start,  // one cycle pulse
  input  layer_cfg_t  layer_cfg,   // sampled with load_start
  input  logic        ddr_ready,   // ddr can take a request
  input  ddr_rd_rsp_t ddr_rd_rsp,  // returned words, in order
  output ddr_rd_req_t ddr_rd_req,
  output buf_port_t   wr_port,     // toward write bank
  output logic        load_done    // cycle after last write
);

  typedef enum logic [1:0] {
    st_idle,     // waiting for load_start
    st_request,  // issuing ddr reads
    st_drain     // all issued, waiting for data
  } state_e;

  state_e      state;
  logic [15:0] word_total;   // words in this tile
  logic [15:0] req_cnt;      // requests accepted
  logic [15:0] rsp_cnt;      // responses written
  logic [15:0] req_addr;     // current ddr address
  logic [15:0] start_words;  // word count from layer_cfg
  logic        req_fire;
  logic        rsp_accept;
  logic        last_req;
  logic        last_rsp;

  // 8bit: one word per vector, 1bit: ceil(vec_count/4)
  always_comb begin
    if (layer_cfg.mode == mode_1bit) begin
      start_words = 16'(({1'b0, layer_cfg.vec_count} + 17'(VECS_PER_WORD_1BIT - 1))
                        / VECS_PER_WORD_1BIT);
    end else begin
      start_words = layer_cfg.vec_count;
    end
  end

  assign req_fire   = ddr_rd_req.valid && ddr_ready;  // request handshake
  assign rsp_accept = ddr_rd_rsp.valid && (state != st_idle);
  assign last_req   = (req_cnt == word_total - 16'd1);
  assign last_rsp   = (rsp_cnt == word_total - 16'd1);

  always_ff @(posedge clk) begin
    if (reset) begin
      state      <= st_idle;
      word_total <= '0;
      req_cnt    <= '0;
      rsp_cnt    <= '0;
      req_addr   <= '0;
      load_done  <= 1'b0;
    end else begin
      load_done <= 1'b0;  // pulse only
      case (state)
        st_idle: begin
          if (load_start) begin
            word_total <= start_words;
            req_addr   <= layer_cfg.ddr_base;
            req_cnt    <= '0;
            rsp_cnt    <= '0;
            if (start_words == 16'd0) begin
              load_done <= 1'b1;  // empty tile, nothing to fetch
            end else begin
              state <= st_request;
            end
          end
        end
        st_request: begin
          if (req_fire) begin  // hold addr while ready low
            req_addr <= req_addr + 16'd1;
            req_cnt  <= req_cnt + 16'd1;
            if (last_req) state <= st_drain;
          end
        end
        default: ;  // drain, only responses move
      endcase
      if (rsp_accept) begin
        rsp_cnt <= rsp_cnt + 16'd1;
        if (last_rsp) begin
          state     <= st_idle;  // tile complete
          load_done <= 1'b1;
        end
      end
    end
  end

  always_comb begin
    ddr_rd_req.valid = (state == st_request);
    ddr_rd_req.addr  = req_addr;
  end

  // response i goes to bank address i, same cycle
  always_comb begin
    wr_port.en   = rsp_accept;
    wr_port.wr   = 1'b1;
    wr_port.addr = 16'(rsp_cnt[BUF_DEPTH_LOG2-1:0]);
    wr_port.data = ddr_rd_rsp.data;
  end

endmodule

/* src/conv_weights_ping_pong_controller.sv */
`timescale 1ns/100ps

module conv_weights_ping_pong_controller
  import conv_weights_pkg::*;
  import weights_mem_pkg::*;
#(
  parameter int BUF_DEPTH_LOG2 = 12  // bank address width
) (
  input  logic              clk,
  input  logic              reset,
  input  logic              load_start,  // swaps the banks
  input  layer_cfg_t        layer_cfg,   // cfg of the tile about to load
  input  buf_port_t         wr_port,     // from load controller
  input  buf_port_t         rd_port,     // from handler
  output logic [WORD_W-1:0] rd_data,     // read bank data, one cycle later
  output layer_cfg_t        read_cfg,    // cfg recorded for read bank
  output buf_port_t         ping_port,
  output buf_port_t         pong_port,
  input  logic [WORD_W-1:0] ping_dout,
  input  logic [WORD_W-1:0] pong_dout
);

  logic       wr_bank;     // 0 ping, 1 pong
  logic       rd_bank;     // always the other one
  logic       rd_bank_q;   // bank behind rd_data
  layer_cfg_t cfg_rec [2]; // one record per bank
  buf_port_t  rd_port_bank;

  assign rd_bank = ~wr_bank;

  //////////////////////////////
  // bank select and cfg record
  //////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_bank    <= 1'b1;  // first load_start makes ping the write bank
      rd_bank_q  <= 1'b0;
      cfg_rec[0] <= LAYER_CFG_EMPTY;
      cfg_rec[1] <= LAYER_CFG_EMPTY;
    end else begin
      if (load_start) begin
        wr_bank          <= ~wr_bank;
        cfg_rec[rd_bank] <= layer_cfg;  // old read bank is the new write bank
      end
      if (rd_port.en) rd_bank_q <= rd_bank;  // survives a swap in flight
    end
  end

  //////////////////////////////
  // port muxing
  //////////////////////////////

  // handler address cut to the bank range
  always_comb begin
    rd_port_bank      = rd_port;
    rd_port_bank.addr = 16'(rd_port.addr[BUF_DEPTH_LOG2-1:0]);
  end

  always_comb begin
    if (wr_bank) begin
      ping_port = rd_port_bank;  // ping readable
      pong_port = wr_port;       // pong filling
    end else begin
      ping_port = wr_port;
      pong_port = rd_port_bank;
    end
  end

  assign rd_data  = rd_bank_q ? pong_dout : ping_dout;
  assign read_cfg = cfg_rec[rd_bank];

endmodule

/* src/cv_weights_handler.sv */
`timescale 1ns/100ps

module cv_weights_handler
  import conv_weights_pkg::*;
  import weights_mem_pkg::*;
(
  input  logic              clk,
  input  logic              reset,
  input  logic              re_fm_en,        // step needs a vector
  input  logic              re_fm_end,       // last step of the tile
  input  layer_cfg_t        read_cfg,        // cfg of the read bank
  output buf_port_t         rd_port,         // read request, step cycle
  input  logic [WORD_W-1:0] rd_data,         // word, one cycle later
  output logic [WORD_W-1:0] weights_vector,  // toward the PEs
  output logic              vector_valid
);

  localparam int SLICE_W     = WORD_W / VECS_PER_WORD_1BIT;  // 128 x 1bit
  localparam int SLICE_IDX_W = $clog2(VECS_PER_WORD_1BIT);

  logic [15:0]            step_cnt;  // vector index in tile
  logic [SLICE_IDX_W-1:0] slice_q;   // slice of the word in flight
  weight_mode_e           mode_q;    // mode of the word in flight
  logic                   valid_q;

  //////////////////////////////
  // step cycle, issue read
  //////////////////////////////

  always_comb begin
    rd_port.en   = re_fm_en;
    rd_port.wr   = 1'b0;
    rd_port.data = '0;
    if (read_cfg.mode == mode_1bit) begin
      rd_port.addr = step_cnt >> SLICE_IDX_W;  // four steps per word
    end else begin
      rd_port.addr = step_cnt;  // one step per word
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      step_cnt <= '0;
      valid_q  <= 1'b0;
    end else begin
      valid_q <= re_fm_en;
      if (re_fm_en) begin
        step_cnt <= re_fm_end ? 16'd0 : step_cnt + 16'd1;  // restart after last
      end
    end
  end

  // travels alongside the ram read
  always_ff @(posedge clk) begin
    if (re_fm_en) begin
      slice_q <= step_cnt[SLICE_IDX_W-1:0];
      mode_q  <= read_cfg.mode;
    end
  end

  //////////////////////////////
  // data cycle, unpack vector
  //////////////////////////////

  always_comb begin
    weights_vector = '0;
    if (mode_q == mode_1bit) begin
      weights_vector[SLICE_W-1:0] = rd_data[slice_q*SLICE_W +: SLICE_W];  // upper bits zero
    end else begin
      weights_vector = rd_data;
    end
  end

  assign vector_valid = valid_q;

endmodule

/* src/conv_weights_top.sv */
`timescale 1ns/100ps

module conv_weights_top
  import conv_weights_pkg::*;
  import weights_mem_pkg::*;
#(
  parameter int BUF_DEPTH_LOG2 = 12  // bank address width
) (
  input  logic              clk,
  input  logic              reset,
  input  logic              load_start,
  input  layer_cfg_t        layer_cfg,
  input  logic              ddr_ready,
  input  ddr_rd_rsp_t       ddr_rd_rsp,
  output ddr_rd_req_t       ddr_rd_req,
  output logic              load_done,
  input  logic              re_fm_en,
  input  logic              re_fm_end,
  output logic [WORD_W-1:0] weights_vector,
  output logic              vector_valid
);

  buf_port_t         wr_port;    // load side
  buf_port_t         rd_port;    // handler side
  buf_port_t         ping_port;
  buf_port_t         pong_port;
  logic [WORD_W-1:0] ping_dout;
  logic [WORD_W-1:0] pong_dout;
  logic [WORD_W-1:0] rd_data;    // muxed bank output
  layer_cfg_t        read_cfg;

  //////////////////////////////
  // load path
  //////////////////////////////

  conv_load_weights_controller #(.BUF_DEPTH_LOG2(BUF_DEPTH_LOG2)) load_ctrl_i (
    .clk        (clk),
    .reset      (reset),
    .load_start (load_start),
    .layer_cfg  (layer_cfg),
    .ddr_ready  (ddr_ready),
    .ddr_rd_rsp (ddr_rd_rsp),
    .ddr_rd_req (ddr_rd_req),
    .wr_port    (wr_port),
    .load_done  (load_done)
  );

  conv_weights_ping_pong_controller #(.BUF_DEPTH_LOG2(BUF_DEPTH_LOG2)) ping_pong_i (
    .clk        (clk),
    .reset      (reset),
    .load_start (load_start),
    .layer_cfg  (layer_cfg),
    .wr_port    (wr_port),
    .rd_port    (rd_port),
    .rd_data    (rd_data),
    .read_cfg   (read_cfg),
    .ping_port  (ping_port),
    .pong_port  (pong_port),
    .ping_dout  (ping_dout),
    .pong_dout  (pong_dout)
  );

  // the two banks
  weights_buffer #(.BUF_DEPTH_LOG2(BUF_DEPTH_LOG2)) ping_buf_i (
    .clk  (clk),
    .port (ping_port),
    .dout (ping_dout)
  );

  weights_buffer #(.BUF_DEPTH_LOG2(BUF_DEPTH_LOG2)) pong_buf_i (
    .clk  (clk),
    .port (pong_port),
    .dout (pong_dout)
  );

  //////////////////////////////
  // stream path
  //////////////////////////////

  cv_weights_handler handler_i (
    .clk            (clk),
    .reset          (reset),
    .re_fm_en       (re_fm_en),
    .re_fm_end      (re_fm_end),
    .read_cfg       (read_cfg),
    .rd_port        (rd_port),
    .rd_data        (rd_data),
    .weights_vector (weights_vector),
    .vector_valid   (vector_valid)
  );

endmodule

/* verif/ddr_weights_model.sv */
`timescale 1ns/100ps

module ddr_weights_model
  import weights_mem_pkg::*;
(
  input  logic        clk,
  input  logic        reset,
  input  logic        ddr_ready,   // request throttle from the testbench
  input  ddr_rd_req_t ddr_rd_req,
  output ddr_rd_rsp_t ddr_rd_rsp   // in order, no back-pressure
);

  logic [15:0] addr_q[$];  // accepted addresses
  int          due_q[$];   // cycle each word returns
  int          cycle;
  int          last_due;

  // 32-bit lanes, every lane depends on the full address
  function automatic logic [WORD_W-1:0] mem_word(input logic [15:0] a);
    logic [WORD_W-1:0] w;
    for (int j = 0; j < WORD_W / 32; j++) begin
      w[j*32 +: 32] = 32'(a) * 32'h9e3779b1 + 32'(j) * 32'h01010101;
    end
    return w;
  endfunction

  initial ddr_rd_rsp = '0;

  always @(posedge clk) begin
    int lat;
    ddr_rd_rsp <= '0;  // valid for one cycle only
    if (reset) begin
      addr_q.delete();
      due_q.delete();
      cycle    = 0;
      last_due = 0;
    end else begin
      cycle = cycle + 1;
      if (addr_q.size() > 0 && due_q[0] <= cycle) begin
        ddr_rd_rsp <= '{valid: 1'b1, data: mem_word(addr_q.pop_front())};
        void'(due_q.pop_front());
      end
      if (ddr_rd_req.valid && ddr_ready) begin
        lat      = 2 + int'(ddr_rd_req.addr % 4);  // 2 to 5 cycles
        last_due = (cycle + lat > last_due) ? cycle + lat : last_due + 1;  // keep order
        addr_q.push_back(ddr_rd_req.addr);
        due_q.push_back(last_due);
      end
    end
  end

endmodule

/* verif/conv_weights_checker.sv */
`timescale 1ns/100ps

module conv_weights_checker
  import weights_mem_pkg::*;
(
  input logic        clk,
  input logic        reset,
  input logic        load_start,
  input logic        load_done,
  input ddr_rd_req_t ddr_rd_req
);

  logic busy;          // load in progress
  int   fail_cnt = 0;  // assertion failures

  always_ff @(posedge clk) begin
    if (reset) begin
      busy <= 1'b0;
    end else if (load_start) begin
      busy <= 1'b1;
    end else if (load_done) begin
      busy <= 1'b0;
    end
  end

  ////////////////////////////////
  // protocol rules
  ////////////////////////////////

  req_idle_in_reset: assert property (@(posedge clk) reset |=> !ddr_rd_req.valid)
    else begin
      $error("ddr request valid while in reset");
      fail_cnt++;
    end

  done_single_cycle: assert property (@(posedge clk) disable iff (reset)
    load_done |=> !load_done)
    else begin
      $error("load_done held longer than one cycle");
      fail_cnt++;
    end

  no_start_while_busy: assert property (@(posedge clk) disable iff (reset)
    busy && !load_done |-> !load_start)
    else begin
      $error("load_start during a running load");
      fail_cnt++;
    end

endmodule

bind conv_weights_top conv_weights_checker chk_i (
  .clk        (clk),
  .reset      (reset),
  .load_start (load_start),
  .load_done  (load_done),
  .ddr_rd_req (ddr_rd_req)
);

/* verif/conv_weights_tb.sv */
`timescale 1ns/100ps

module conv_weights_tb
  import conv_weights_pkg::*;
  import weights_mem_pkg::*;
;

  localparam layer_cfg_t CFG_A = '{mode: mode_8bit, vec_count: 16'd18, ddr_base: 16'h0040};
  localparam layer_cfg_t CFG_B = '{mode: mode_1bit, vec_count: 16'd10, ddr_base: 16'h0100};
  localparam layer_cfg_t CFG_C = '{mode: mode_8bit, vec_count: 16'd12, ddr_base: 16'h0200};
  localparam layer_cfg_t CFG_D = '{mode: mode_8bit, vec_count: 16'd2,  ddr_base: 16'h0300};
  localparam int TOTAL_WORDS    = 18 + 3 + 12 + 2;
  localparam int TOTAL_STEPS    = 18 + 10 + 12;
  localparam int TIMEOUT_CYCLES = TOTAL_WORDS * 8 + TOTAL_STEPS + 200;

  logic              clk;
  logic              reset;
  logic              load_start;
  logic              ddr_ready;
  logic              re_fm_en;
  logic              re_fm_end;
  logic              load_done;
  logic              vector_valid;
  layer_cfg_t        layer_cfg;
  ddr_rd_req_t       ddr_rd_req;
  ddr_rd_rsp_t       ddr_rd_rsp;
  logic [WORD_W-1:0] weights_vector;
  logic [WORD_W-1:0] exp_q[$];  // expected vectors, step order
  int                step_q[$]; // cycle of each step
  integer            seed = 32'hce848c45;
  logic [31:0]       rnd;
  bit                throttle = 1'b0;
  int                cycles = 0;
  int                errors = 0;
  int                checks = 0;
  int                done_cnt = 0;
  int                total_err;
  bit                started = 1'b0;
  bit                stalled = 1'b0;
  logic [15:0]       stall_addr;
  logic [15:0]       exp_addr;
  int                exp_words;
  int                req_seen;

  conv_weights_top dut_i (.*);
  ddr_weights_model ddr_i (.*);

  initial clk = 1'b0;
  always #20 clk = ~clk;  // 40 ns

  ////////////////////////////////
  // reference model
  ////////////////////////////////

  function automatic logic [WORD_W-1:0] ref_word(input logic [15:0] a);
    logic [WORD_W-1:0] w;
    for (int j = 0; j < 16; j++) w[32*j +: 32] = 32'(a) * 32'h9e3779b1 + 32'(j) * 32'h01010101;
    return w;
  endfunction

  function automatic logic [WORD_W-1:0] ref_vector(input layer_cfg_t cfg, input int i);
    logic [WORD_W-1:0] w;
    logic [WORD_W-1:0] v;
    v = '0;
    if (cfg.mode == mode_1bit) begin
      w          = ref_word(cfg.ddr_base + 16'(i / 4));
      v[127:0]   = w[(i % 4) * 128 +: 128];  // four 128-bit vectors per word
    end else begin
      v = ref_word(cfg.ddr_base + 16'(i));
    end
    return v;
  endfunction

  function automatic int words_for(input layer_cfg_t cfg);
    return (cfg.mode == mode_1bit) ? (int'(cfg.vec_count) + 3) / 4 : int'(cfg.vec_count);
  endfunction

  ////////////////////////////////
  // stimulus
  ////////////////////////////////

  task automatic run_load(input layer_cfg_t cfg);
    @(posedge clk);
    load_start <= 1'b1;
    layer_cfg  <= cfg;
    @(posedge clk);
    load_start <= 1'b0;
    @(posedge clk);
    while (!load_done) @(posedge clk);  // until the tile sits in its bank
  endtask

  task automatic stream(input layer_cfg_t cfg, input int n);
    for (int i = 0; i < n; i++) begin
      @(posedge clk);
      re_fm_en  <= 1'b1;
      re_fm_end <= (i == n - 1);
      exp_q.push_back(ref_vector(cfg, i));
    end
    @(posedge clk);
    re_fm_en  <= 1'b0;
    re_fm_end <= 1'b0;
  endtask

  always @(posedge clk) begin
    rnd = $random(seed);
    ddr_ready <= throttle ? rnd[0] : 1'b1;
  end

  ////////////////////////////////
  // monitors and compare
  ////////////////////////////////

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("=== FAIL ===");
      $finish;
    end
  end

  always @(posedge clk) begin
    if (!reset) begin
      if (!started) begin  // quiet before first load
        checks++;
        assert (!ddr_rd_req.valid && !load_done && !vector_valid) else begin
          $display("ERROR %0t: activity before load_start", $time);
          errors++;
        end
      end
      if (load_done) begin
        done_cnt++;
        checks++;
        assert (req_seen == exp_words) else begin
          $display("ERROR %0t: %0d requests, expected %0d", $time, req_seen, exp_words);
          errors++;
        end
      end
      if (stalled) begin  // request must hold while ready low
        checks++;
        assert (ddr_rd_req.valid && ddr_rd_req.addr == stall_addr) else begin
          $display("ERROR %0t: request dropped or moved while ready low", $time);
          errors++;
        end
      end
      if (ddr_rd_req.valid && ddr_ready) begin
        checks++;
        assert (ddr_rd_req.addr == exp_addr) else begin
          $display("ERROR %0t: request addr %h, expected %h", $time, ddr_rd_req.addr, exp_addr);
          errors++;
        end
        exp_addr = exp_addr + 16'd1;
        req_seen++;
      end
      stalled    = ddr_rd_req.valid && !ddr_ready;
      stall_addr = ddr_rd_req.addr;
      if (load_start) begin
        started   = 1'b1;
        exp_addr  = layer_cfg.ddr_base;
        exp_words = words_for(layer_cfg);
        req_seen  = 0;
      end
    end
  end

  always @(posedge clk) begin
    if (!reset) begin
      if (vector_valid) begin
        checks++;
        assert (exp_q.size() > 0 && step_q.size() > 0) else begin
          $display("ERROR %0t: vector_valid without a pending step", $time);
          errors++;
        end
        if (exp_q.size() > 0 && step_q.size() > 0) begin
          assert (weights_vector === exp_q[0]) else begin
            $display("ERROR %0t: vector mismatch, got %h", $time, weights_vector[127:0]);
            errors++;
          end
          assert (cycles == step_q[0] + 1) else begin
            $display("ERROR %0t: vector not one cycle after its step", $time);
            errors++;
          end
          void'(exp_q.pop_front());
          void'(step_q.pop_front());
        end
      end
      if (re_fm_en) step_q.push_back(cycles);
    end
  end

  initial begin
    reset      = 1'b1;
    load_start = 1'b0;
    layer_cfg  = '0;
    ddr_ready  = 1'b1;
    re_fm_en   = 1'b0;
    re_fm_end  = 1'b0;
    repeat (5) @(posedge clk);
    reset <= 1'b0;
    repeat (4) @(posedge clk);  // idle window after reset
    run_load(CFG_A);
    throttle = 1'b1;  // random ready from here on
    fork
      run_load(CFG_B);
      begin  // overlaps the B load
        @(posedge clk);
        stream(CFG_A, 18);
      end
    join
    fork
      run_load(CFG_C);
      begin
        @(posedge clk);
        stream(CFG_B, 10);
      end
    join
    fork
      run_load(CFG_D);
      begin
        @(posedge clk);
        stream(CFG_C, 12);
      end
    join
    while (exp_q.size() > 0) @(posedge clk);
    repeat (2) @(posedge clk);
    checks++;
    assert (done_cnt == 4) else begin
      $display("ERROR %0t: %0d load_done pulses, expected 4", $time, done_cnt);
      errors++;
    end
    total_err = errors + dut_i.chk_i.fail_cnt;
    $display("checks %0d, errors %0d", checks, total_err);
    if (total_err == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

/* conv_weights_top.f */
src/conv_weights_pkg.sv
src/weights_mem_pkg.sv
src/weights_buffer.sv
src/conv_load_weights_controller.sv
src/conv_weights_ping_pong_controller.sv
src/cv_weights_handler.sv
src/conv_weights_top.sv
verif/ddr_weights_model.sv
verif/conv_weights_checker.sv
verif/conv_weights_tb.sv
